// File: compile.f
verilog/fpu_pkg.sv
verilog/fpu_ctrl.sv
verilog/fpu_decode.sv
verilog/fpu_add_sub.sv
verilog/fpu_mul.sv
verilog/fpu_result.sv
verilog/fpu_top.sv
dv/fpu_assert.sv
dv/fpu_tb.sv

// File: Bender.yml
package:
  name: fpu

sources:
  - verilog/fpu_pkg.sv
  - verilog/fpu_ctrl.sv
  - verilog/fpu_decode.sv
  - verilog/fpu_add_sub.sv
  - verilog/fpu_mul.sv
  - verilog/fpu_result.sv
  - verilog/fpu_top.sv
  - target: test
    files:
      - dv/fpu_assert.sv
      - dv/fpu_tb.sv

// File: dv/fpu_tb.sv
/*
  fpu testbench
  runs a table of add/sub/mul cases through the start/cmd_end exchange
*/
`timescale 1ns/1ps

module fpu_tb;

  typedef struct {
    fpu_pkg::fpu_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      expected;
    string            name;
  } test_vec_t;

  localparam int n_tests      = 17;
  localparam int reset_cycles = 2;
  localparam int hold_cycles  = 5;
  // 20 cycles per entry plus reset and the idle check
  localparam int max_cycles   = 20 * n_tests + reset_cycles + 4;

  // results exact or rounded as the add and multiply units define
  test_vec_t tests [n_tests] = '{
    '{fpu_pkg::op_add, 32'h3fc00000, 32'h3fc00000, 32'h40400000, "add 1.5+1.5 carry"},
    '{fpu_pkg::op_add, 32'h3f800000, 32'h40000000, 32'h40400000, "add 1.0+2.0"},
    '{fpu_pkg::op_add, 32'h40400000, 32'hbf800000, 32'h40000000, "add 3.0+(-1.0)"},
    '{fpu_pkg::op_add, 32'hc0400000, 32'h3f800000, 32'hc0000000, "add -3.0+1.0"},
    '{fpu_pkg::op_add, 32'h3fc00000, 32'hbf800000, 32'h3f000000, "add 1.5+(-1.0)"},
    '{fpu_pkg::op_add, 32'h3f800000, 32'h33800000, 32'h3f800000, "add 1.0+2^-24 trunc"},
    '{fpu_pkg::op_sub, 32'h40200000, 32'h40200000, 32'h00000000, "sub 2.5-2.5"},
    '{fpu_pkg::op_sub, 32'h40400000, 32'h3f800000, 32'h40000000, "sub 3.0-1.0"},
    '{fpu_pkg::op_sub, 32'h3f800000, 32'h40800000, 32'hc0400000, "sub 1.0-4.0"},
    '{fpu_pkg::op_sub, 32'hc0000000, 32'hbf000000, 32'hbfc00000, "sub -2.0-(-0.5)"},
    '{fpu_pkg::op_sub, 32'h40000000, 32'hc0000000, 32'h40800000, "sub 2.0-(-2.0)"},
    '{fpu_pkg::op_mul, 32'h3fc00000, 32'h3fc00000, 32'h40100000, "mul 1.5*1.5"},
    '{fpu_pkg::op_mul, 32'h40000000, 32'hc0400000, 32'hc0c00000, "mul 2.0*-3.0"},
    '{fpu_pkg::op_mul, 32'h3f800001, 32'h3ffffffe, 32'h40000000, "mul round carry"},
    '{fpu_pkg::op_mul, 32'h3fc00000, 32'h3f800003, 32'h3fc00004, "mul tie stays even"},
    '{fpu_pkg::op_mul, 32'h3fc00000, 32'h3f800001, 32'h3fc00002, "mul tie rounds up"},
    '{fpu_pkg::op_mul, 32'h3f000000, 32'h40800000, 32'h40000000, "mul 0.5*4.0"}
  };

  logic                clk;
  logic                arst;
  logic [31:0]         a_operand;
  logic [31:0]         b_operand;
  fpu_pkg::fpu_op_e    operation;
  logic                start;
  fpu_pkg::fp_packet_t result;
  logic                cmd_end;
  logic                busy;

  int cycle_count = 0;
  int pass_count  = 0;
  int fail_count  = 0;

  fpu_top u_fpu_top (
    .clk       (clk),
    .arst      (arst),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .operation (operation),
    .start     (start),
    .result    (result),
    .cmd_end   (cmd_end),
    .busy      (busy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // inputs change 2 ns after the edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic tally(input string name, input int errs);
    if (errs == 0) begin
      pass_count++;
      $display("pass  %s", name);
    end else begin
      fail_count++;
      $display("fail  %s", name);
    end
  endtask

  task automatic run_entry(input int idx);
    int errs;
    errs      = 0;
    a_operand = tests[idx].a;
    b_operand = tests[idx].b;
    operation = tests[idx].op;
    start     = 1'b1;
    next_cycle();
    if (!busy) begin
      $display("%0t: busy did not rise after start in %s", $time, tests[idx].name);
      errs++;
    end
    while (!cmd_end) next_cycle();
    if (result !== tests[idx].expected) begin
      $display("[ERROR] %0t: %s expected %08h got %08h", $time, tests[idx].name,
               tests[idx].expected, result);
      errs++;
    end
    // requester is free to change operands once cmd_end is seen
    a_operand = ~tests[idx].a;
    b_operand = tests[idx].a;
    if (tests[idx].op == fpu_pkg::op_mul) begin
      operation = fpu_pkg::op_add;
    end else begin
      operation = fpu_pkg::op_mul;
    end
    repeat (hold_cycles) begin
      next_cycle();
      if (!cmd_end) begin
        $display("%0t: cmd_end dropped while start was held", $time);
        errs++;
      end
      if (!busy) begin
        $display("%0t: busy dropped while start was held", $time);
        errs++;
      end
      if (result !== tests[idx].expected) begin
        $display("[ERROR] %0t: %s result %08h during hold, expected %08h",
                 $time, tests[idx].name, result, tests[idx].expected);
        errs++;
      end
    end
    start = 1'b0;
    next_cycle();
    if (cmd_end) begin
      $display("%0t: cmd_end still high one cycle after start dropped", $time);
      errs++;
    end
    if (busy) begin
      $display("%0t: busy still high one cycle after start dropped", $time);
      errs++;
    end
    // new operands must not reach the output during the idle gap
    next_cycle();
    if (result !== tests[idx].expected) begin
      $display("[ERROR] %0t: %s result %08h with no operation, expected %08h",
               $time, tests[idx].name, result, tests[idx].expected);
      errs++;
    end
    tally(tests[idx].name, errs);
  endtask

  initial begin
    int errs;
    arst      = 1'b1;
    start     = 1'b0;
    a_operand = '0;
    b_operand = '0;
    operation = fpu_pkg::op_add;
    repeat (reset_cycles) @(posedge clk);
    #2;
    arst = 1'b0;
    // state straight out of reset
    next_cycle();
    errs = 0;
    if (result !== 32'h0) begin
      $display("[ERROR] %0t: reset result expected 00000000 got %08h", $time, result);
      errs++;
    end
    if (busy) begin
      $display("%0t: busy high after reset", $time);
      errs++;
    end
    if (cmd_end) begin
      $display("%0t: cmd_end high after reset", $time);
      errs++;
    end
    tally("reset state", errs);
    for (int i = 0; i < n_tests; i++) begin
      run_entry(i);
    end
    $display("%0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dv/fpu_assert.sv
/*
  fpu handshake checks
  bound into fpu_top, watches the start/cmd_end exchange and result stability
*/
`timescale 1ns/1ps

module fpu_assert (
  input logic                 clk,
  input logic                 arst,
  input logic                 start,
  input logic                 busy,
  input logic                 cmd_end,
  input fpu_pkg::fp_packet_t  result,
  input fpu_pkg::ctrl_state_e state
);

  // done is only ever signalled inside a busy window
  a_end_busy: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else $error("cmd_end high while busy is low");

  // packet frozen while the requester may still read it
  a_result_stable: assert property (@(posedge clk) disable iff (arst)
    cmd_end |=> $stable(result))
    else $error("result moved while cmd_end was high");

  // release of start closes the exchange on the next edge
  a_end_fall: assert property (@(posedge clk) disable iff (arst)
    (state == fpu_pkg::st_done) && !start |=> !cmd_end && !busy)
    else $error("cmd_end or busy still high after start dropped");

  // start seen in idle opens the exchange
  a_busy_rise: assert property (@(posedge clk) disable iff (arst)
    (state == fpu_pkg::st_idle) && start |=> busy)
    else $error("busy did not rise after start in idle");

endmodule

bind fpu_top fpu_assert u_fpu_assert (
  .clk     (clk),
  .arst    (arst),
  .start   (start),
  .busy    (busy),
  .cmd_end (cmd_end),
  .result  (result),
  .state   (u_fpu_ctrl.state_q)
);

// File: verilog/fpu_top.sv
/*
  fpu top
  single-precision add/sub/mul unit with a four-phase start/cmd_end handshake
*/
`timescale 1ns/1ps

module fpu_top (
  input  logic                      clk,
  input  logic                      arst,
  input  logic [fpu_pkg::fp_w-1:0]  a_operand,
  input  logic [fpu_pkg::fp_w-1:0]  b_operand,
  input  fpu_pkg::fpu_op_e          operation,
  input  logic                      start,
  output fpu_pkg::fp_packet_t       result,
  output logic                      cmd_end,
  output logic                      busy
);

  // controller strobes
  logic load;
  logic capture;

  // registered operands and opcode
  fpu_pkg::fp_unpacked_t a_dec;
  fpu_pkg::fp_unpacked_t b_dec;
  fpu_pkg::fpu_op_e      op_q;

  // unit results, both computed every cycle
  fpu_pkg::fp_packet_t sum;
  fpu_pkg::fp_packet_t product;

  fpu_ctrl u_fpu_ctrl (
    .clk     (clk),
    .arst    (arst),
    .start   (start),
    .load    (load),
    .capture (capture),
    .busy    (busy),
    .cmd_end (cmd_end)
  );

  fpu_decode u_fpu_decode (
    .clk       (clk),
    .arst      (arst),
    .load      (load),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .operation (operation),
    .a_dec     (a_dec),
    .b_dec     (b_dec),
    .op_q      (op_q)
  );

  fpu_add_sub u_fpu_add_sub (
    .a_dec (a_dec),
    .b_dec (b_dec),
    .op_q  (op_q),
    .sum   (sum)
  );

  fpu_mul u_fpu_mul (
    .a_dec   (a_dec),
    .b_dec   (b_dec),
    .product (product)
  );

  fpu_result u_fpu_result (
    .clk     (clk),
    .arst    (arst),
    .capture (capture),
    .op_q    (op_q),
    .sum     (sum),
    .product (product),
    .result  (result)
  );

endmodule

// File: verilog/fpu_result.sv
/*
  result stage
  picks the unit result for the held opcode and registers the output packet
*/
`timescale 1ns/1ps

module fpu_result (
  input  logic                  clk,
  input  logic                  arst,
  input  logic                  capture,
  input  fpu_pkg::fpu_op_e      op_q,
  input  fpu_pkg::fp_packet_t   sum,
  input  fpu_pkg::fp_packet_t   product,
  output fpu_pkg::fp_packet_t   result
);

  fpu_pkg::fp_packet_t sel;

  // add and sub share one unit
  always_comb begin
    case (op_q)
      fpu_pkg::op_mul: sel = product;
      default:         sel = sum;
    endcase
  end

  // packet held until the next operation captures
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      result <= '0;
    end else if (capture) begin
      result <= sel;
    end
  end

endmodule

// File: verilog/fpu_mul.sv
/*
  multiply unit
  24x24 significand product, normalization and round to nearest even
*/
`timescale 1ns/1ps

module fpu_mul (
  input  fpu_pkg::fp_unpacked_t a_dec,
  input  fpu_pkg::fp_unpacked_t b_dec,
  output fpu_pkg::fp_packet_t   product
);

  logic [2*fpu_pkg::sig_w-1:0] prod;
  logic [2*fpu_pkg::sig_w-1:0] prod_norm;
  logic [fpu_pkg::sig_w:0]     rounded;
  logic [fpu_pkg::frac_w-1:0]  mant;
  logic [fpu_pkg::exp_w-1:0]   exp_sum;
  logic [fpu_pkg::exp_w-1:0]   exp_norm;
  logic [fpu_pkg::exp_w-1:0]   exp_res;
  logic                        guard;
  logic                        sticky;
  logic                        round_up;

  // product of two 1.x values lies in [1, 4)
  assign prod    = a_dec.sig * b_dec.sig;
  assign exp_sum = a_dec.exp + b_dec.exp - fpu_pkg::exp_bias;

  // top bit set means 1x.xxx, bump exponent
  // otherwise shift so the leading one sits in the top bit
  assign prod_norm = prod[2*fpu_pkg::sig_w-1] ? prod : prod << 1;
  assign exp_norm  = prod[2*fpu_pkg::sig_w-1] ? exp_sum + 1'b1 : exp_sum;

  // guard is the first dropped bit, sticky the rest
  assign guard  = prod_norm[fpu_pkg::sig_w-1];
  assign sticky = |prod_norm[fpu_pkg::sig_w-2:0];

  // ties go up only when the kept lsb is odd
  assign round_up = guard & (sticky | prod_norm[fpu_pkg::sig_w]);

  // extra top bit catches the rounding carry
  assign rounded = prod_norm[2*fpu_pkg::sig_w-1:fpu_pkg::sig_w] + round_up;

  // carry turns 1.111.. into 10.000.., renormalize once more
  assign mant    = rounded[fpu_pkg::sig_w] ? rounded[fpu_pkg::frac_w:1]
                                           : rounded[fpu_pkg::frac_w-1:0];
  assign exp_res = rounded[fpu_pkg::sig_w] ? exp_norm + 1'b1 : exp_norm;

  assign product.sign = a_dec.sign ^ b_dec.sign;
  assign product.exp  = exp_res;
  assign product.frac = mant;

endmodule

// File: verilog/fpu_add_sub.sv
/*
  add/subtract unit
  aligns exponents, adds in two's complement and renormalizes the magnitude
*/
`timescale 1ns/1ps

module fpu_add_sub (
  input  fpu_pkg::fp_unpacked_t a_dec,
  input  fpu_pkg::fp_unpacked_t b_dec,
  input  fpu_pkg::fpu_op_e      op_q,
  output fpu_pkg::fp_packet_t   sum
);

  // two upper bits per significand, carry at sig_w and sign at the top
  logic [fpu_pkg::add_w-1:0] a_ext;
  logic [fpu_pkg::add_w-1:0] b_ext;
  logic [fpu_pkg::add_w-1:0] a_shift;
  logic [fpu_pkg::add_w-1:0] b_shift;
  logic [fpu_pkg::add_w-1:0] a_tc;
  logic [fpu_pkg::add_w-1:0] b_tc;
  logic [fpu_pkg::add_w-1:0] raw;
  logic [fpu_pkg::add_w-1:0] mag;
  logic [fpu_pkg::add_w-1:0] norm;
  logic                      res_sign;
  logic [fpu_pkg::exp_w-1:0] exp_max;
  logic [fpu_pkg::exp_w-1:0] exp_diff;
  logic [fpu_pkg::exp_w-1:0] exp_res;
  logic [4:0]                lz;

  // leading zeros of the significand field, highest set bit wins
  function automatic logic [4:0] lzc(input logic [fpu_pkg::sig_w-1:0] v);
    logic [4:0] n;
    n = '0;
    for (int i = 0; i < fpu_pkg::sig_w; i++) begin
      if (v[i]) n = 5'(fpu_pkg::sig_w - 1 - i);
    end
    return n;
  endfunction

  assign a_ext = {2'b00, a_dec.sig};
  assign b_ext = {2'b00, b_dec.sig};

  // smaller exponent side is shifted right, low bits truncated
  assign exp_diff = (a_dec.exp < b_dec.exp) ? b_dec.exp - a_dec.exp : a_dec.exp - b_dec.exp;
  assign exp_max  = (a_dec.exp < b_dec.exp) ? b_dec.exp : a_dec.exp;
  assign a_shift  = (a_dec.exp < b_dec.exp) ? a_ext >> exp_diff : a_ext;
  assign b_shift  = (b_dec.exp < a_dec.exp) ? b_ext >> exp_diff : b_ext;

  // negative operands into two's complement
  assign a_tc = a_dec.sign ? -a_shift : a_shift;
  assign b_tc = b_dec.sign ? -b_shift : b_shift;

  always_comb begin
    raw      = (op_q == fpu_pkg::op_sub) ? a_tc - b_tc : a_tc + b_tc;
    res_sign = raw[fpu_pkg::add_w-1];
    mag      = res_sign ? -raw : raw;
    lz       = lzc(mag[fpu_pkg::sig_w-1:0]);
    if (mag == '0) begin
      // full cancellation, exponent forced to zero
      norm    = '0;
      exp_res = '0;
    end else if (mag[fpu_pkg::sig_w]) begin
      // carry out of the hidden bit position
      norm    = mag >> 1;
      exp_res = exp_max + 1'b1;
    end else begin
      // bring the leading one back to the hidden bit
      norm    = mag << lz;
      exp_res = exp_max - lz;
    end
  end

  assign sum.sign = res_sign;
  assign sum.exp  = exp_res;
  assign sum.frac = norm[fpu_pkg::frac_w-1:0];

endmodule

// File: verilog/fpu_decode.sv
/*
  operand decode
  splits both ieee operands into sign, exponent and significand and holds them with the opcode
*/
`timescale 1ns/1ps

module fpu_decode (
  input  logic                      clk,
  input  logic                      arst,
  input  logic                      load,
  input  logic [fpu_pkg::fp_w-1:0]  a_operand,
  input  logic [fpu_pkg::fp_w-1:0]  b_operand,
  input  fpu_pkg::fpu_op_e          operation,
  output fpu_pkg::fp_unpacked_t     a_dec,
  output fpu_pkg::fp_unpacked_t     b_dec,
  output fpu_pkg::fpu_op_e          op_q
);

  // hidden bit is 1 unless the exponent field is zero
  function automatic fpu_pkg::fp_unpacked_t unpack(input logic [fpu_pkg::fp_w-1:0] x);
    fpu_pkg::fp_packet_t   p;
    fpu_pkg::fp_unpacked_t u;
    p      = x;
    u.sign = p.sign;
    u.exp  = p.exp;
    u.sig  = {p.exp != '0, p.frac};
    return u;
  endfunction

  // held stable while the requester is free to change its inputs
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      a_dec <= '0;
      b_dec <= '0;
      op_q  <= fpu_pkg::op_add;
    end else if (load) begin
      a_dec <= unpack(a_operand);
      b_dec <= unpack(b_operand);
      op_q  <= operation;
    end
  end

endmodule

// File: verilog/fpu_ctrl.sv
/*
  fpu controller
  sequences load, execute and capture and runs the start/cmd_end exchange
*/
`timescale 1ns/1ps

module fpu_ctrl (
  input  logic clk,
  input  logic arst,
  input  logic start,
  output logic load,
  output logic capture,
  output logic busy,
  output logic cmd_end
);

  fpu_pkg::ctrl_state_e state_q;
  fpu_pkg::ctrl_state_e state_d;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      fpu_pkg::st_idle:
        if (start) state_d = fpu_pkg::st_load;
      // operands go into decode registers
      fpu_pkg::st_load:
        state_d = fpu_pkg::st_exec;
      // units settle, result stage captures
      fpu_pkg::st_exec:
        state_d = fpu_pkg::st_done;
      // hold the packet until the requester lets go of start
      fpu_pkg::st_done:
        if (!start) state_d = fpu_pkg::st_wait_low;
      fpu_pkg::st_wait_low:
        state_d = fpu_pkg::st_idle;
      default:
        state_d = fpu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state_q <= fpu_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // outputs registered from the next state
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      load    <= 1'b0;
      capture <= 1'b0;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      load    <= 1'b0;
      capture <= 1'b0;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
      case (state_d)
        fpu_pkg::st_load: begin
          load <= 1'b1;
          busy <= 1'b1;
        end
        fpu_pkg::st_exec: begin
          capture <= 1'b1;
          busy    <= 1'b1;
        end
        fpu_pkg::st_done: begin
          cmd_end <= 1'b1;
          busy    <= 1'b1;
        end
        // idle and wait_low keep everything low
        default: begin
        end
      endcase
    end
  end

endmodule

// File: verilog/fpu_pkg.sv
/*
  fpu package
  single-precision format widths, opcodes, controller states and the operand/result layouts
*/
package fpu_pkg;

  // ieee-754 single precision layout
  localparam int unsigned fp_w   = 32;
  localparam int unsigned exp_w  = 8;
  localparam int unsigned frac_w = 23;

  // fraction plus the hidden bit
  localparam int unsigned sig_w = 24;

  // significand plus a carry bit and a sign bit for two's complement add/sub
  localparam int unsigned add_w = 26;

  // exponent bias, sized to the exponent field
  localparam logic [exp_w-1:0] exp_bias = 8'd127;

  // arithmetic operation requested by the host
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } fpu_op_e;

  // controller states
  typedef enum logic [2:0] {
    st_idle     = 3'd0,
    st_load     = 3'd1,
    st_exec     = 3'd2,
    st_done     = 3'd3,
    st_wait_low = 3'd4
  } ctrl_state_e;

  // one decoded operand, hidden bit already in place
  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exp;
    logic [sig_w-1:0] sig;
  } fp_unpacked_t;

  // ieee packet as seen on the output and at each unit
  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [frac_w-1:0] frac;
  } fp_packet_t;

endpackage
